// File: rtl/elevator_settings.svh
// Floor count, floor number width and reset values for the elevator request logic
`ifndef ELEVATOR_SETTINGS_SVH
`define ELEVATOR_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Building geometry
////////////////////////////////////////////////////////////

// Served floors, numbered 0 (lowest) upward
`define FLOOR_COUNT 11

// Bits needed to carry a floor number
`define FLOOR_WIDTH 4

////////////////////////////////////////////////////////////
// Reset values of the dispatcher
////////////////////////////////////////////////////////////

`define RESET_TARGET 0
`define RESET_DIRECTION_UP 1'b1

`endif

// File: rtl/elevator_pkg.sv
// Floor number, floor mask, car status and dispatch command types
`include "elevator_settings.svh"

package elevator_pkg;

    ////////////////////////////////////////////////////////////
    // Plain vector types
    ////////////////////////////////////////////////////////////

    // Floor number, 0 is the lowest floor
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, bit k stands for floor k
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    ////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////

    // Reported by the car
    typedef struct packed {
        floor_t floor;
        logic   moving;
        // Last travel direction, 1 is up
        logic   heading_up;
    } car_status_t;

    // Sent to the car
    typedef struct packed {
        floor_t target;
        logic   direction_up;
        // Start request while the car is stopped away from the target
        logic   activate;
    } dispatch_t;

endpackage

// File: rtl/request_register.sv
// Request lamp bank, set by buttons and cleared when the car stops at a floor
module request_register (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      enable,
    input  elevator_pkg::floor_mask_t buttons,
    input  elevator_pkg::car_status_t car,
    output elevator_pkg::floor_mask_t lights
);

    // Floor where the car stands still, empty while it moves
    elevator_pkg::floor_mask_t stop_mask;
    elevator_pkg::floor_mask_t lights_next;

    ////////////////////////////////////////////////////////////
    // Next lamp state
    ////////////////////////////////////////////////////////////

    always_comb begin
        stop_mask = '0;
        if (!car.moving) begin
            // A floor number past the top shifts out and selects nothing
            stop_mask = elevator_pkg::floor_mask_t'(1) << car.floor;
        end
    end

    // New presses light up, the stop floor is held dark
    // A press at the stop floor is absorbed by the same mask
    assign lights_next = (lights | buttons) & ~stop_mask;

    ////////////////////////////////////////////////////////////
    // Lamp register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else if (enable) begin
            lights <= lights_next;
        end
    end

    // Lamps hold while the bank is disabled
    // (emergency or power off), so no press is lost or cleared

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // After an enabled edge with the car stopped, its floor lamp is dark
    property stop_floor_cleared;
        @(posedge clock) disable iff (!reset_n)
        (enable && !car.moving) |=> !lights[$past(car.floor)];
    endproperty

    assert property (stop_floor_cleared)
        else $error("request lamp still lit at the floor where the car stopped");

endmodule

// File: rtl/floor_scheduler.sv
// Next target search over the lit requests with a direction preference
`include "elevator_settings.svh"

module floor_scheduler (
    input  elevator_pkg::floor_mask_t pending,
    input  elevator_pkg::car_status_t car,
    output elevator_pkg::floor_t      next_target,
    output logic                      has_target
);

    // Lit floors on each side of the car, its own floor excluded
    elevator_pkg::floor_mask_t above_mask;
    elevator_pkg::floor_mask_t below_mask;
    logic                      any_above;
    logic                      any_below;

    ////////////////////////////////////////////////////////////
    // Priority helpers
    ////////////////////////////////////////////////////////////

    // Lowest set bit, zero when the mask is empty
    function automatic elevator_pkg::floor_t lowest_set(
        input elevator_pkg::floor_mask_t mask
    );
        elevator_pkg::floor_t result;
        result = '0;
        // Scan downward so the lowest hit wins
        for (int k = `FLOOR_COUNT - 1; k >= 0; k--) begin
            if (mask[k]) begin
                result = elevator_pkg::floor_t'(k);
            end
        end
        return result;
    endfunction

    // Highest set bit, zero when the mask is empty
    function automatic elevator_pkg::floor_t highest_set(
        input elevator_pkg::floor_mask_t mask
    );
        elevator_pkg::floor_t result;
        result = '0;
        for (int k = 0; k < `FLOOR_COUNT; k++) begin
            if (mask[k]) begin
                result = elevator_pkg::floor_t'(k);
            end
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////
    // Split the requests around the car
    ////////////////////////////////////////////////////////////

    always_comb begin
        above_mask = '0;
        below_mask = '0;
        for (int k = 0; k < `FLOOR_COUNT; k++) begin
            above_mask[k] = pending[k] && (k > int'(car.floor));
            below_mask[k] = pending[k] && (k < int'(car.floor));
        end
    end

    assign any_above  = |above_mask;
    assign any_below  = |below_mask;
    assign has_target = any_above || any_below;

    ////////////////////////////////////////////////////////////
    // Nearest floor in the heading, else turn around
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (car.heading_up) begin
            if (any_above) begin
                next_target = lowest_set(above_mask);
            end else begin
                next_target = highest_set(below_mask);
            end
        end else begin
            if (any_below) begin
                next_target = highest_set(below_mask);
            end else begin
                next_target = lowest_set(above_mask);
            end
        end
    end

    // With no request on either side the value is floor 0,
    // and has_target tells the dispatcher to ignore it

endmodule

// File: rtl/car_dispatch.sv
// Target register, travel direction, activate strobe and door button gating
`include "elevator_settings.svh"

module car_dispatch (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      enable,
    input  logic                      power_on,
    input  elevator_pkg::floor_t      next_target,
    input  logic                      has_target,
    input  elevator_pkg::car_status_t car,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    output elevator_pkg::dispatch_t   command,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    elevator_pkg::floor_t target_q;
    logic                 direction_up_q;
    logic                 car_stopped;
    logic                 load_target;
    logic                 activate;

    assign car_stopped = !car.moving;

    // Pick a new target only once the car has served the current one
    assign load_target = car_stopped && (car.floor == target_q) && has_target;

    ////////////////////////////////////////////////////////////
    // Target register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_q       <= elevator_pkg::floor_t'(`RESET_TARGET);
            direction_up_q <= `RESET_DIRECTION_UP;
        end else if (load_target) begin
            target_q       <= next_target;
            direction_up_q <= (next_target > car.floor);
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    assign activate = enable && car_stopped && (target_q != car.floor);

    always_comb begin
        command.target       = target_q;
        command.direction_up = direction_up_q;
        command.activate     = activate;
    end

    // Doors respond only to a powered car at rest
    assign door_open_allowed  = door_open_button && power_on && car_stopped;
    assign door_close_allowed = door_close_button && power_on && car_stopped;

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // A start request sent to the car points away from its floor
    property activate_away_from_car;
        @(posedge clock) disable iff (!reset_n)
        command.activate |-> (command.target != car.floor);
    endproperty

    assert property (activate_away_from_car)
        else $error("activate sent with the target at the car floor");

endmodule

// File: rtl/floor_logic_top.sv
// Elevator request logic top level with two lamp banks, scheduler and dispatcher
module floor_logic_top (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t hall_buttons,
    input  elevator_pkg::floor_mask_t car_buttons,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    input  logic                      emergency,
    input  logic                      power_on,
    input  elevator_pkg::car_status_t car,
    output elevator_pkg::dispatch_t   command,
    output elevator_pkg::floor_mask_t hall_lights,
    output elevator_pkg::floor_mask_t car_lights,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    logic                      enable;
    elevator_pkg::floor_mask_t pending;
    elevator_pkg::floor_t      next_target;
    logic                      has_target;

    // Requests are served only with power on and no emergency
    assign enable = power_on && !emergency;

    // Hall and car requests weigh the same for scheduling
    assign pending = hall_lights | car_lights;

    ////////////////////////////////////////////////////////////
    // Request banks
    ////////////////////////////////////////////////////////////

    request_register u_hall_requests (
        .clock   (clock),
        .reset_n (reset_n),
        .enable  (enable),
        .buttons (hall_buttons),
        .car     (car),
        .lights  (hall_lights)
    );

    request_register u_car_requests (
        .clock   (clock),
        .reset_n (reset_n),
        .enable  (enable),
        .buttons (car_buttons),
        .car     (car),
        .lights  (car_lights)
    );

    ////////////////////////////////////////////////////////////
    // Scheduling and dispatch
    ////////////////////////////////////////////////////////////

    floor_scheduler u_floor_scheduler (
        .pending     (pending),
        .car         (car),
        .next_target (next_target),
        .has_target  (has_target)
    );

    car_dispatch u_car_dispatch (
        .clock              (clock),
        .reset_n            (reset_n),
        .enable             (enable),
        .power_on           (power_on),
        .next_target        (next_target),
        .has_target         (has_target),
        .car                (car),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .command            (command),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// File: tests/floor_logic_tb.sv
// Testbench for the elevator request logic with car model, reference model and assertions
`include "elevator_settings.svh"

module floor_logic_tb;

    localparam int TEST_CYCLES  = 3000;
    localparam int RESET_CYCLES = 5;

    logic                      clock;
    logic                      reset_n;
    elevator_pkg::floor_mask_t hall_buttons;
    elevator_pkg::floor_mask_t car_buttons;
    logic                      door_open_button;
    logic                      door_close_button;
    logic                      emergency;
    logic                      power_on;
    elevator_pkg::car_status_t car;
    elevator_pkg::dispatch_t   command;
    elevator_pkg::floor_mask_t hall_lights;
    elevator_pkg::floor_mask_t car_lights;
    logic                      door_open_allowed;
    logic                      door_close_allowed;

    logic [31:0] rnd_state;
    int          step_timer;
    int          lamp_errors;
    int          target_errors;
    int          inhibit_errors;
    int          door_errors;
    int          target_loads;

    // Reference model state
    elevator_pkg::floor_mask_t exp_hall;
    elevator_pkg::floor_mask_t exp_car;
    elevator_pkg::floor_t      exp_target;
    logic                      exp_direction_up;
    logic                      enable_ref;
    int                        predicted;
    logic                      clear_check;
    elevator_pkg::floor_t      clear_floor;

    floor_logic_top u_floor_logic_top (
        .clock              (clock),
        .reset_n            (reset_n),
        .hall_buttons       (hall_buttons),
        .car_buttons        (car_buttons),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .emergency          (emergency),
        .power_on           (power_on),
        .car                (car),
        .command            (command),
        .hall_lights        (hall_lights),
        .car_lights         (car_lights),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic is_lit(input elevator_pkg::floor_mask_t mask, input int f);
        return (mask & (elevator_pkg::floor_mask_t'(1) << f)) != '0;
    endfunction

    // Mostly idle, sometimes one floor, rarely a burst of floors
    function automatic elevator_pkg::floor_mask_t random_presses(input logic [31:0] r);
        elevator_pkg::floor_mask_t mask;
        mask = '0;
        if (r[2:0] == 3'd0) begin
            mask = elevator_pkg::floor_mask_t'(1) << (int'(r[15:8]) % `FLOOR_COUNT);
        end else if (r[7:3] == 5'd0) begin
            mask = elevator_pkg::floor_mask_t'(r[31:21]);
        end
        return mask;
    endfunction

    // Lamp k is lit after the edge if it was lit or pressed, unless the car rests there
    function automatic elevator_pkg::floor_mask_t next_lamps(
        input elevator_pkg::floor_mask_t lamps,
        input elevator_pkg::floor_mask_t buttons,
        input elevator_pkg::car_status_t status
    );
        elevator_pkg::floor_mask_t result;
        result = '0;
        for (int k = 0; k < `FLOOR_COUNT; k++) begin
            if (is_lit(lamps | buttons, k) && (status.moving || k != int'(status.floor))) begin
                result = result | (elevator_pkg::floor_mask_t'(1) << k);
            end
        end
        return result;
    endfunction

    // Walk outward in the heading first, then the other way; -1 when nothing is lit
    function automatic int nearest_request(
        input elevator_pkg::floor_mask_t mask,
        input int                        here,
        input logic                      up
    );
        int step;
        int found;
        found = -1;
        step  = up ? 1 : -1;
        for (int f = here + step; f >= 0 && f < `FLOOR_COUNT; f += step) begin
            if (found < 0 && is_lit(mask, f)) begin
                found = f;
            end
        end
        for (int f = here - step; f >= 0 && f < `FLOOR_COUNT; f -= step) begin
            if (found < 0 && is_lit(mask, f)) begin
                found = f;
            end
        end
        return found;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    always_comb begin
        enable_ref = power_on && !emergency;
        predicted  = nearest_request(exp_hall | exp_car, int'(car.floor), car.heading_up);
    end

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            exp_hall         <= '0;
            exp_car          <= '0;
            exp_target       <= '0;
            exp_direction_up <= 1'b1;
            clear_check      <= 1'b0;
            clear_floor      <= '0;
            target_loads     <= 0;
        end else begin
            if (enable_ref) begin
                exp_hall <= next_lamps(exp_hall, hall_buttons, car);
                exp_car  <= next_lamps(exp_car, car_buttons, car);
            end
            // New target only once the car rests at the old one
            if (!car.moving && car.floor == exp_target && predicted >= 0) begin
                exp_target       <= elevator_pkg::floor_t'(predicted);
                exp_direction_up <= predicted > int'(car.floor);
                target_loads     <= target_loads + 1;
            end
            clear_check <= enable_ref && !car.moving;
            clear_floor <= car.floor;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clock) disable iff (!reset_n) hall_lights == exp_hall)
        else begin
            lamp_errors++;
            $display("error hall_lights got %h expected %h",
                     $sampled(hall_lights), $sampled(exp_hall));
        end

    assert property (@(posedge clock) disable iff (!reset_n) car_lights == exp_car)
        else begin
            lamp_errors++;
            $display("error car_lights got %h expected %h",
                     $sampled(car_lights), $sampled(exp_car));
        end

    assert property (@(posedge clock) disable iff (!reset_n)
                     clear_check |-> !hall_lights[clear_floor] && !car_lights[clear_floor])
        else begin
            lamp_errors++;
            $display("lamp still lit at floor %0d after the car stopped there",
                     $sampled(clear_floor));
        end

    assert property (@(posedge clock) disable iff (!reset_n)
                     command.target == exp_target && command.direction_up == exp_direction_up)
        else begin
            target_errors++;
            $display("error command.target got %h expected %h, direction_up got %h expected %h",
                     $sampled(command.target), $sampled(exp_target),
                     $sampled(command.direction_up), $sampled(exp_direction_up));
        end

    assert property (@(posedge clock) disable iff (!reset_n)
                     command.activate == (enable_ref && !car.moving && exp_target != car.floor))
        else begin
            inhibit_errors++;
            $display("error command.activate got %h expected %h", $sampled(command.activate),
                     $sampled(enable_ref && !car.moving && exp_target != car.floor));
        end

    assert property (@(posedge clock) disable iff (!reset_n)
                     !enable_ref |=> $stable(hall_lights) && $stable(car_lights))
        else begin
            inhibit_errors++;
            $display("request lamps changed while requests were inhibited");
        end

    assert property (@(posedge clock) disable iff (!reset_n)
                     door_open_allowed == (door_open_button && power_on && !car.moving))
        else begin
            door_errors++;
            $display("error door_open_allowed got %h expected %h", $sampled(door_open_allowed),
                     $sampled(door_open_button && power_on && !car.moving));
        end

    assert property (@(posedge clock) disable iff (!reset_n)
                     door_close_allowed == (door_close_button && power_on && !car.moving))
        else begin
            door_errors++;
            $display("error door_close_allowed got %h expected %h", $sampled(door_close_allowed),
                     $sampled(door_close_button && power_on && !car.moving));
        end

    ////////////////////////////////////////////////////////////
    // Car model and stimulus
    ////////////////////////////////////////////////////////////

    // One floor every four cycles, stopping only at the target
    task automatic move_car();
        if (car.moving) begin
            if (step_timer > 0) begin
                step_timer--;
            end else begin
                car.floor  = car.heading_up ? car.floor + 1'b1 : car.floor - 1'b1;
                step_timer = 3;
                if (car.floor == command.target) begin
                    car.moving = 1'b0;
                end
            end
        end else if (command.activate) begin
            car.moving     = 1'b1;
            car.heading_up = command.target > car.floor;
            step_timer     = 3;
        end
    endtask

    task automatic drive_inputs(input int cycle);
        logic [31:0] hall_rnd;
        rnd_state         = xorshift(rnd_state);
        hall_rnd          = rnd_state;
        rnd_state         = xorshift(rnd_state);
        hall_buttons      = random_presses(hall_rnd);
        car_buttons       = random_presses(rnd_state);
        door_open_button  = rnd_state[16];
        door_close_button = rnd_state[17];
        // Inhibit windows
        emergency = (cycle >= 900 && cycle < 1100);
        power_on  = !(cycle >= 1900 && cycle < 2100);
    endtask

    initial begin
        reset_n           = 1'b0;
        hall_buttons      = '0;
        car_buttons       = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency         = 1'b0;
        power_on          = 1'b1;
        car               = '0;
        rnd_state         = 32'h4e6e;
        step_timer        = 0;
        lamp_errors       = 0;
        target_errors     = 0;
        inhibit_errors    = 0;
        door_errors       = 0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset_n = 1'b1;
        for (int cycle = 0; cycle < TEST_CYCLES; cycle++) begin
            @(negedge clock);
            move_car();
            drive_inputs(cycle);
        end
        @(negedge clock);
        $display(
            "lamp errors %0d, target errors %0d, inhibit errors %0d, door errors %0d, loads %0d",
            lamp_errors, target_errors, inhibit_errors, door_errors, target_loads);
        if (lamp_errors + target_errors + inhibit_errors + door_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TEST_CYCLES * 16);
        $display("watchdog expired before the stimulus finished");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: sim.f
+incdir+rtl
rtl/elevator_pkg.sv
rtl/request_register.sv
rtl/floor_scheduler.sv
rtl/car_dispatch.sv
rtl/floor_logic_top.sv
tests/floor_logic_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := floor_logic_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) rtl/elevator_settings.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
